// ==== build.f ====
design/demodPkg.sv
design/demodCtrlIf.sv
design/demodRegs.sv
design/falseLockDetector.sv
design/magnitudeFilter.sv
design/symbolDeskew.sv
design/dacMonitor.sv
design/demodCore.sv
verif/demodTb.sv

// ==== verif/demodTrace.txt ====
# w addr data byteEn | r addr word name | d iDdc qDdc freq freqErr phase mag | s iResamp qResamp
# k dac idleCycle strobe name | c dac data name | f flag name | y iSym qSym name
r 000 00000000 modeAfterReset
r 001 00000000 lockAfterReset
r 002 00000000 dacAfterReset
r 003 00000000 statusAfterReset
w 001 12345678 f
r 001 12345678 lockFullWrite
w 001 aabbccdd 5
r 001 12bb56dd lockByteWrite
w 041 ffffffff f
r 001 12bb56dd lockOutsideSpace
r 041 00000000 readOutsideSpace
w 000 ffffffff f
r 000 00001f0f modeMasked
w 003 ffffffff f
r 003 00000000 statusReadOnly
r 004 00000000 unmappedOffset
w 002 00000987 3
r 002 00000987 dacSelectWrite
w 000 00000001 f
w 001 00000000 f
w 002 00000910 f
d 01234 3abcd 05 fe 7f 000
k 0 0 1 dacIStrobe
c 0 01234 dacIData
c 1 3abcd dacQData
c 2 01234 undefinedCode
w 002 00000654 f
d 00011 00022 0c f3 81 000
k 2 0 1 dacMagStrobe
c 0 03000 dacFreqData
c 1 20400 dacPhaseData
c 2 20000 dacMagIdle
w 002 00000873 f
d 00011 00022 0c f3 81 000
k 0 0 0 symbolNoDdcStrobe
k 1 0 1 avgFreqStrobe
c 1 00000 avgFreqIdle
c 2 3cc00 freqErrorData
s 00100 00200
k 0 0 0 qSymStrobeEarly
k 0 1 1 qSymStrobe
c 0 00200 qSymData
y 00100 00200 qpskDeskew
w 002 00000002 f
s 00300 00400
k 0 1 1 iSymStrobe
c 0 00300 iSymData
y 00300 00400 qpskDeskew2
w 000 00000002 f
s 00500 00600
y 00500 00400 oqpskDeskew
s 00700 00800
y 00700 00600 oqpskDeskew2
w 000 00000001 f
w 002 00000067 f
d 00000 00000 00 10 00 000
w 001 36b04000 f
d 00000 00000 00 10 00 000
c 0 02000 avgStep1
f 0 flagStep1
d 00000 00000 00 10 00 000
c 0 02fff avgStep2
f 0 flagStep2
d 00000 00000 00 10 00 000
c 0 037ff avgStep3
f 0 flagStep3
d 00000 00000 00 10 00 000
c 0 03bff avgStep4
f 1 flagRises
r 003 00000001 statusFollowsFlag
w 000 00000002 f
d 00000 00000 f0 10 00 000
c 0 03dff oqpskAvg1
d 00000 00000 f0 10 00 000
c 0 3feff oqpskAvg2
f 1 oqpskFlagHeld
d 00000 00000 f0 10 00 000
c 0 3df7f oqpskAvg3
f 0 oqpskFlagFalls
r 003 00000000 statusCleared
w 000 00001401 f
d 00000 00000 00 00 00 100
c 1 20000 magStep1
d 00000 00000 00 00 00 100
c 1 20020 magStep2
d 00000 00000 00 00 00 100
c 1 20040 magStep3
w 000 00001f01 f
d 00000 00000 00 00 00 100
c 1 30040 magStep4
d 00000 00000 00 00 00 100
c 1 00040 magStep5
d 00000 00000 00 00 00 100
c 1 08040 magStep6

// ==== verif/demodTb.sv ====
`default_nettype none

module demodTb;

    logic clk;
    logic reset;
    demodPkg::addr_t addr;
    demodPkg::word_t din;
    logic [3:0] wrEn;
    demodPkg::word_t dout;
    logic ddcSync;
    demodPkg::sample_t iDdc;
    demodPkg::sample_t qDdc;
    demodPkg::disc_t freq;
    demodPkg::disc_t freqError;
    demodPkg::disc_t phase;
    demodPkg::mag_t mag;
    logic resampSync;
    demodPkg::sample_t iResamp;
    demodPkg::sample_t qResamp;
    logic highFreqOffset;
    logic symSync;
    demodPkg::sample_t iSym;
    demodPkg::sample_t qSym;
    logic dac0Sync;
    logic dac1Sync;
    logic dac2Sync;
    demodPkg::sample_t dac0Data;
    demodPkg::sample_t dac1Data;
    demodPkg::sample_t dac2Data;
    demodPkg::dacSource_t dac0Select;
    demodPkg::dacSource_t dac1Select;
    demodPkg::dacSource_t dac2Select;

    int passCount = 0;
    int failCount = 0;
    int cycleCount = 0;
    int cycleLimit = 0;
    // strobe history per DAC over the three idle cycles after a pulse
    logic [2:0] syncSeen [3];
    demodPkg::sample_t capturedI = '0;
    demodPkg::sample_t capturedQ = '0;
    string traceLines [$];

    demodCore dut (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // limit grows with the trace, each line needs at most four cycles
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if ((cycleLimit > 0) && (cycleCount >= cycleLimit)) begin
            $display("run timed out after %0d cycles", cycleCount);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic checkWord(input string name, input demodPkg::word_t expected,
                             input demodPkg::word_t actual);
        if (actual === expected) begin
            passCount++;
            $display("ok    %s", name);
        end else begin
            failCount++;
            $display("Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkSample(input string name, input demodPkg::sample_t expected,
                               input demodPkg::sample_t actual);
        if (actual === expected) begin
            passCount++;
            $display("ok    %s", name);
        end else begin
            failCount++;
            $display("Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual === expected) begin
            passCount++;
            $display("ok    %s", name);
        end else begin
            failCount++;
            $display("Error %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic checkSelect(input string name, input demodPkg::dacSource_t expected,
                               input demodPkg::dacSource_t actual);
        if (actual === expected) begin
            passCount++;
            $display("ok    %s", name);
        end else begin
            failCount++;
            $display("Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    function automatic logic dacSyncAt(input int ch);
        case (ch)
            0: return dac0Sync;
            1: return dac1Sync;
            default: return dac2Sync;
        endcase
    endfunction

    function automatic demodPkg::sample_t dacDataAt(input int ch);
        case (ch)
            0: return dac0Data;
            1: return dac1Data;
            default: return dac2Data;
        endcase
    endfunction

    task automatic writeReg(input demodPkg::addr_t a, input demodPkg::word_t data,
                            input logic [3:0] byteEn);
        addr = a;
        din = data;
        wrEn = byteEn;
        @(negedge clk);
        wrEn = 4'b0000;
    endtask

    // one strobe cycle, then three idle cycles
    task automatic pulseStrobe(input logic isDdc);
        ddcSync = isDdc;
        resampSync = !isDdc;
        for (int ch = 0; ch < 3; ch++) begin
            syncSeen[ch] = '0;
        end
        for (int idle = 0; idle < 3; idle++) begin
            @(negedge clk);
            ddcSync = 1'b0;
            resampSync = 1'b0;
            for (int ch = 0; ch < 3; ch++) begin
                syncSeen[ch][idle] = dacSyncAt(ch);
            end
            // symbol values are taken while symSync marks them
            if (symSync) begin
                capturedI = iSym;
                capturedQ = qSym;
            end
        end
    endtask

    task automatic runLine(input string line);
        string cmd;
        string name;
        logic [31:0] f0;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        logic [31:0] f5;
        int count;
        int wanted;
        count = $sscanf(line, "%s", cmd);
        wanted = 1;
        if (cmd == "w") begin
            count = $sscanf(line, "%s %h %h %h", cmd, f0, f1, f2);
            wanted = 4;
            writeReg(f0[11:0], f1, f2[3:0]);
        end else if (cmd == "r") begin
            count = $sscanf(line, "%s %h %h %s", cmd, f0, f1, name);
            wanted = 4;
            addr = f0[11:0];
            @(negedge clk);
            checkWord(name, f1, dout);
            // select outputs carry the dac select fields
            if (f0[11:0] == {demodPkg::demodSpaceBase, demodPkg::regDacSelect}) begin
                checkSelect(name, demodPkg::dacSource_t'(f1[3:0]), dac0Select);
                checkSelect(name, demodPkg::dacSource_t'(f1[7:4]), dac1Select);
                checkSelect(name, demodPkg::dacSource_t'(f1[11:8]), dac2Select);
            end
        end else if (cmd == "d") begin
            count = $sscanf(line, "%s %h %h %h %h %h %h", cmd, f0, f1, f2, f3, f4, f5);
            wanted = 7;
            iDdc = f0[17:0];
            qDdc = f1[17:0];
            freq = f2[7:0];
            freqError = f3[7:0];
            phase = f4[7:0];
            mag = f5[8:0];
            pulseStrobe(1'b1);
        end else if (cmd == "s") begin
            count = $sscanf(line, "%s %h %h", cmd, f0, f1);
            wanted = 3;
            iResamp = f0[17:0];
            qResamp = f1[17:0];
            pulseStrobe(1'b0);
        end else if (cmd == "k") begin
            count = $sscanf(line, "%s %d %d %d %s", cmd, f0, f1, f2, name);
            wanted = 5;
            checkFlag(name, f2[0], syncSeen[f0][f1]);
        end else if (cmd == "c") begin
            count = $sscanf(line, "%s %d %h %s", cmd, f0, f1, name);
            wanted = 4;
            checkSample(name, f1[17:0], dacDataAt(f0));
        end else if (cmd == "f") begin
            count = $sscanf(line, "%s %d %s", cmd, f0, name);
            wanted = 3;
            checkFlag(name, f0[0], highFreqOffset);
        end else if (cmd == "y") begin
            count = $sscanf(line, "%s %h %h %s", cmd, f0, f1, name);
            wanted = 4;
            checkSample(name, f0[17:0], capturedI);
            checkSample(name, f1[17:0], capturedQ);
        end else begin
            failCount++;
            $display("trace line not understood: %s", line);
        end
        if (count != wanted) begin
            failCount++;
            $display("trace line has missing fields: %s", line);
        end
    endtask

    initial begin
        int fd;
        string line;
        reset = 1'b1;
        addr = '0;
        din = '0;
        wrEn = 4'b0000;
        ddcSync = 1'b0;
        iDdc = '0;
        qDdc = '0;
        freq = '0;
        freqError = '0;
        phase = '0;
        mag = '0;
        resampSync = 1'b0;
        iResamp = '0;
        qResamp = '0;
        fd = $fopen("verif/demodTrace.txt", "r");
        if (fd == 0) begin
            failCount++;
            $display("could not open the trace file verif/demodTrace.txt");
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) > 0) begin
                    traceLines.push_back(line);
                end
            end
            $fclose(fd);
        end
        cycleLimit = traceLines.size() * 8 + 100;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        foreach (traceLines[n]) begin
            if ((traceLines[n].len() > 1) && (traceLines[n].substr(0, 0) != "#")) begin
                runLine(traceLines[n]);
            end
        end
        $display("%0d checks passed, %0d checks failed", passCount, failCount);
        if (failCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/demodCore.sv ====
`default_nettype none

module demodCore #(
    parameter int avgWidth = demodPkg::sampleWidth,
    parameter int accumWidth = 40
) (
    input wire logic clk,
    input wire logic reset,
    input wire demodPkg::addr_t addr,
    input wire demodPkg::word_t din,
    input wire logic [3:0] wrEn,
    output demodPkg::word_t dout,
    input wire logic ddcSync,
    input wire demodPkg::sample_t iDdc,
    input wire demodPkg::sample_t qDdc,
    input wire demodPkg::disc_t freq,
    input wire demodPkg::disc_t freqError,
    input wire demodPkg::disc_t phase,
    input wire demodPkg::mag_t mag,
    input wire logic resampSync,
    input wire demodPkg::sample_t iResamp,
    input wire demodPkg::sample_t qResamp,
    output logic highFreqOffset,
    output logic symSync,
    output demodPkg::sample_t iSym,
    output demodPkg::sample_t qSym,
    output logic dac0Sync,
    output logic dac1Sync,
    output logic dac2Sync,
    output demodPkg::sample_t dac0Data,
    output demodPkg::sample_t dac1Data,
    output demodPkg::sample_t dac2Data,
    output demodPkg::dacSource_t dac0Select,
    output demodPkg::dacSource_t dac1Select,
    output demodPkg::dacSource_t dac2Select
);

    demodPkg::sample_t averageFreq;
    demodPkg::sample_t magEstimate;
    logic dacSync [3];
    demodPkg::sample_t dacData [3];

    demodSettingsIf settings ();
    discStreamIf disc ();

    // detector stream from the external fm detector
    assign disc.ddcSync = ddcSync;
    assign disc.freq = freq;
    assign disc.freqError = freqError;
    assign disc.phase = phase;
    assign disc.mag = mag;

    demodRegs regs (
        .clk(clk), .reset(reset), .addr(addr), .din(din), .wrEn(wrEn),
        .highFreqOffset(highFreqOffset), .dout(dout), .settings(settings.regs)
    );

    falseLockDetector #(.avgWidth(avgWidth)) detector (
        .clk(clk), .reset(reset), .settings(settings.detector), .disc(disc.sink),
        .averageFreq(averageFreq), .highFreqOffset(highFreqOffset)
    );

    magnitudeFilter #(.accumWidth(accumWidth)) magFilter (
        .clk(clk), .reset(reset), .settings(settings.filter), .disc(disc.sink),
        .magEstimate(magEstimate)
    );

    symbolDeskew deskew (
        .clk(clk), .reset(reset), .settings(settings.deskew),
        .resampSync(resampSync), .iResamp(iResamp), .qResamp(qResamp),
        .symSync(symSync), .iSym(iSym), .qSym(qSym)
    );

    dacMonitor #(.numDacs(3)) monitor (
        .clk(clk), .reset(reset), .settings(settings.monitor), .disc(disc.sink),
        .iDdc(iDdc), .qDdc(qDdc), .symSync(symSync), .iSym(iSym), .qSym(qSym),
        .averageFreq(averageFreq), .magEstimate(magEstimate),
        .dacSync(dacSync), .dacData(dacData)
    );

    assign dac0Sync = dacSync[0];
    assign dac1Sync = dacSync[1];
    assign dac2Sync = dacSync[2];
    assign dac0Data = dacData[0];
    assign dac1Data = dacData[1];
    assign dac2Data = dacData[2];
    assign dac0Select = settings.dac0Select;
    assign dac1Select = settings.dac1Select;
    assign dac2Select = settings.dac2Select;

endmodule

`default_nettype wire

// ==== design/dacMonitor.sv ====
`default_nettype none

module dacMonitor #(
    parameter int numDacs = 3
) (
    input wire logic clk,
    input wire logic reset,
    demodSettingsIf.monitor settings,
    discStreamIf.sink disc,
    input wire demodPkg::sample_t iDdc,
    input wire demodPkg::sample_t qDdc,
    input wire logic symSync,
    input wire demodPkg::sample_t iSym,
    input wire demodPkg::sample_t qSym,
    input wire demodPkg::sample_t averageFreq,
    input wire demodPkg::sample_t magEstimate,
    output logic dacSync [numDacs],
    output demodPkg::sample_t dacData [numDacs]
);

    // discriminator outputs scaled up to full sample range
    demodPkg::sample_t freqScaled;
    demodPkg::sample_t phaseScaled;
    demodPkg::sample_t freqErrorScaled;

    assign freqScaled = demodPkg::sample_t'(disc.freq) <<< demodPkg::discScale;
    assign phaseScaled = demodPkg::sample_t'(disc.phase) <<< demodPkg::discScale;
    assign freqErrorScaled = demodPkg::sample_t'(disc.freqError) <<< demodPkg::discScale;

    for (genvar ch = 0; ch < numDacs; ch++) begin : gChannel
        demodPkg::dacSource_t select;
        logic syncReg;
        demodPkg::sample_t dataReg;

        // channels past the third share the last select register
        if (ch == 0) begin : gSel0
            assign select = settings.dac0Select;
        end else if (ch == 1) begin : gSel1
            assign select = settings.dac1Select;
        end else begin : gSelN
            assign select = settings.dac2Select;
        end

        always_ff @(posedge clk) begin
            case (select)
                demodPkg::dacI: dataReg <= iDdc;
                demodPkg::dacQ: dataReg <= qDdc;
                demodPkg::dacISym: dataReg <= iSym;
                demodPkg::dacQSym: dataReg <= qSym;
                demodPkg::dacFreq: dataReg <= freqScaled;
                demodPkg::dacPhase: dataReg <= phaseScaled;
                demodPkg::dacMag: dataReg <= magEstimate;
                demodPkg::dacAvgFreq: dataReg <= averageFreq;
                demodPkg::dacFreqError: dataReg <= freqErrorScaled;
                default: dataReg <= iDdc;
            endcase
        end

        // symbol sources run on the symbol strobe, all else on ddc
        always_ff @(posedge clk) begin
            if (reset) begin
                syncReg <= 1'b0;
            end else if ((select == demodPkg::dacISym) || (select == demodPkg::dacQSym)) begin
                syncReg <= symSync;
            end else begin
                syncReg <= disc.ddcSync;
            end
        end

        assign dacSync[ch] = syncReg;
        assign dacData[ch] = dataReg;
    end

endmodule

`default_nettype wire

// ==== design/symbolDeskew.sv ====
`default_nettype none

module symbolDeskew (
    input wire logic clk,
    input wire logic reset,
    demodSettingsIf.deskew settings,
    input wire logic resampSync,
    input wire demodPkg::sample_t iResamp,
    input wire demodPkg::sample_t qResamp,
    output logic symSync,
    output demodPkg::sample_t iSym,
    output demodPkg::sample_t qSym
);

    demodPkg::sample_t qDelay;

    always_ff @(posedge clk) begin
        if (resampSync) begin
            iSym <= iResamp;
            qDelay <= qResamp;
            // Q lags I by half a symbol in offset qpsk
            if (settings.demodMode == demodPkg::modeOqpsk) begin
                qSym <= qDelay;
            end else begin
                qSym <= qResamp;
            end
        end
    end

    // marks fresh iSym and qSym
    always_ff @(posedge clk) begin
        if (reset) begin
            symSync <= 1'b0;
        end else begin
            symSync <= resampSync;
        end
    end

endmodule

`default_nettype wire

// ==== design/magnitudeFilter.sv ====
`default_nettype none

module magnitudeFilter #(
    parameter int accumWidth = 40
) (
    input wire logic clk,
    input wire logic reset,
    demodSettingsIf.filter settings,
    discStreamIf.sink disc,
    output demodPkg::sample_t magEstimate
);

    logic signed [9:0] magError;
    logic signed [accumWidth-1:0] magAccum;
    logic signed [accumWidth-1:0] magStep;

    // loop gain set by amTC, larger shift means a shorter time constant
    assign magStep = accumWidth'($signed(magError[9:2])) <<< settings.amTC;

    always_ff @(posedge clk) begin
        if (reset) begin
            magError <= '0;
            magAccum <= '0;
        end else if (disc.ddcSync) begin
            magError <= {1'b0, disc.mag} - magAccum[accumWidth-1 -: 10];
            // step uses the error from the previous strobe
            magAccum <= magAccum + magStep;
        end
    end

    // offset binary to two's complement for the DAC
    assign magEstimate = {
        ~magAccum[accumWidth-2],
        magAccum[accumWidth-3 -: demodPkg::sampleWidth-1]
    };

endmodule

`default_nettype wire

// ==== design/falseLockDetector.sv ====
`default_nettype none

module falseLockDetector #(
    parameter int avgWidth = demodPkg::sampleWidth
) (
    input wire logic clk,
    input wire logic reset,
    demodSettingsIf.detector settings,
    discStreamIf.sink disc,
    output demodPkg::sample_t averageFreq,
    output logic highFreqOffset
);

    // one spare bit so alpha*4 stays positive for any alpha
    localparam int coefWidth = avgWidth + 1;
    localparam int sumWidth = avgWidth + coefWidth + 1;
    localparam int padWidth = avgWidth - demodPkg::sampleWidth;
    localparam int alphaShift = avgWidth - 16;
    localparam logic signed [coefWidth-1:0] unityLess =
        coefWidth'((64'd1 << (avgWidth - 1)) - 64'd1);

    logic signed [avgWidth-1:0] freqSample;
    logic signed [avgWidth-1:0] average;
    logic signed [coefWidth-1:0] alphaCoef;
    logic signed [coefWidth-1:0] leakCoef;
    logic signed [sumWidth-1:0] alphaSum;
    demodPkg::sample_t newSample;
    logic [demodPkg::sampleWidth-1:0] absAverage;

    assign alphaCoef = {1'b0, settings.falseLockAlpha, {alphaShift{1'b0}}};
    assign leakCoef = unityLess - alphaCoef;

    // leaky average, both products from the old register values
    assign alphaSum = freqSample * alphaCoef + average * leakCoef;

    // oqpsk has no usable freq error so the raw freq is averaged
    always_comb begin
        if (settings.demodMode == demodPkg::modeOqpsk) begin
            newSample = demodPkg::sample_t'(disc.freq) <<< demodPkg::discScale;
        end else begin
            newSample = demodPkg::sample_t'(disc.freqError) <<< demodPkg::discScale;
        end
    end

    assign averageFreq = average[avgWidth-1 -: demodPkg::sampleWidth];
    assign absAverage = averageFreq[demodPkg::sampleWidth-1] ? -averageFreq : averageFreq;

    always_ff @(posedge clk) begin
        if (reset) begin
            freqSample <= '0;
            average <= '0;
            highFreqOffset <= 1'b0;
        end else if (disc.ddcSync) begin
            freqSample <= avgWidth'(newSample) <<< padWidth;
            average <= alphaSum[2*avgWidth-2 : avgWidth-1];
            highFreqOffset <= (absAverage > settings.falseLockThreshold);
        end
    end

endmodule

`default_nettype wire

// ==== design/demodRegs.sv ====
`default_nettype none

module demodRegs (
    input wire logic clk,
    input wire logic reset,
    input wire demodPkg::addr_t addr,
    input wire demodPkg::word_t din,
    input wire logic [3:0] wrEn,
    input wire logic highFreqOffset,
    output demodPkg::word_t dout,
    demodSettingsIf.regs settings
);

    // implemented bits per register, the rest read zero
    localparam demodPkg::word_t modeMask = 32'h0000_1f0f;
    localparam demodPkg::word_t lockMask = 32'hffff_ffff;
    localparam demodPkg::word_t dacMask  = 32'h0000_0fff;

    logic inSpace;
    logic [5:0] wordAddr;
    demodPkg::word_t modeReg;
    demodPkg::word_t lockReg;
    demodPkg::word_t dacReg;

    function automatic demodPkg::word_t byteWrite(
        input demodPkg::word_t oldWord,
        input demodPkg::word_t newData,
        input logic [3:0] byteEn,
        input demodPkg::word_t mask
    );
        demodPkg::word_t result;
        result = oldWord;
        for (int b = 0; b < 4; b++) begin
            if (byteEn[b]) begin
                result[b*8 +: 8] = newData[b*8 +: 8] & mask[b*8 +: 8];
            end
        end
        return result;
    endfunction

    assign inSpace = (addr[11:6] == demodPkg::demodSpaceBase);
    assign wordAddr = addr[5:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            modeReg <= '0;
            lockReg <= '0;
            dacReg <= '0;
        end else if (inSpace && (wrEn != 4'b0000)) begin
            case (wordAddr)
                demodPkg::regMode: modeReg <= byteWrite(modeReg, din, wrEn, modeMask);
                demodPkg::regFalseLock: lockReg <= byteWrite(lockReg, din, wrEn, lockMask);
                demodPkg::regDacSelect: dacReg <= byteWrite(dacReg, din, wrEn, dacMask);
                // status is read only
                default: ;
            endcase
        end
    end

    // read back, combinational from addr
    always_comb begin
        dout = '0;
        if (inSpace) begin
            case (wordAddr)
                demodPkg::regMode: dout = modeReg;
                demodPkg::regFalseLock: dout = lockReg;
                demodPkg::regDacSelect: dout = dacReg;
                demodPkg::regStatus: dout = demodPkg::word_t'(highFreqOffset);
                default: dout = '0;
            endcase
        end
    end

    assign settings.demodMode = demodPkg::demodMode_t'(modeReg[3:0]);
    assign settings.amTC = modeReg[12:8];
    assign settings.falseLockAlpha = lockReg[15:0];
    assign settings.falseLockThreshold = lockReg[31:16];
    assign settings.dac0Select = demodPkg::dacSource_t'(dacReg[3:0]);
    assign settings.dac1Select = demodPkg::dacSource_t'(dacReg[7:4]);
    assign settings.dac2Select = demodPkg::dacSource_t'(dacReg[11:8]);

endmodule

`default_nettype wire

// ==== design/demodCtrlIf.sv ====
`default_nettype none

// register settings fanned out from the register block
interface demodSettingsIf;
    demodPkg::demodMode_t demodMode;
    logic [4:0] amTC;
    logic [15:0] falseLockAlpha;
    logic [15:0] falseLockThreshold;
    demodPkg::dacSource_t dac0Select;
    demodPkg::dacSource_t dac1Select;
    demodPkg::dacSource_t dac2Select;

    modport regs (
        output demodMode, amTC, falseLockAlpha, falseLockThreshold,
        output dac0Select, dac1Select, dac2Select
    );
    modport detector (input demodMode, falseLockAlpha, falseLockThreshold);
    modport filter (input amTC);
    modport deskew (input demodMode);
    modport monitor (input dac0Select, dac1Select, dac2Select);
endinterface

// detector outputs at the ddc sample rate
interface discStreamIf;
    logic ddcSync;
    demodPkg::disc_t freq;
    demodPkg::disc_t freqError;
    demodPkg::disc_t phase;
    demodPkg::mag_t mag;

    modport source (output ddcSync, freq, freqError, phase, mag);
    modport sink (input ddcSync, freq, freqError, phase, mag);
endinterface

`default_nettype wire

// ==== design/demodPkg.sv ====
`default_nettype none

package demodPkg;

    localparam int sampleWidth = 18;

    typedef logic signed [sampleWidth-1:0] sample_t;
    typedef logic signed [7:0] disc_t;
    typedef logic [8:0] mag_t;
    typedef logic [31:0] word_t;
    typedef logic [11:0] addr_t;

    // only modeOqpsk changes behavior in this block
    typedef enum logic [3:0] {
        modeBpsk  = 4'd0,
        modeQpsk  = 4'd1,
        modeOqpsk = 4'd2,
        mode2Fsk  = 4'd3,
        modeFm    = 4'd4
    } demodMode_t;

    typedef enum logic [3:0] {
        dacI         = 4'd0,
        dacQ         = 4'd1,
        dacISym      = 4'd2,
        dacQSym      = 4'd3,
        dacFreq      = 4'd4,
        dacPhase     = 4'd5,
        dacMag       = 4'd6,
        dacAvgFreq   = 4'd7,
        dacFreqError = 4'd8
    } dacSource_t;

    // upper address bits claimed by this block
    localparam logic [5:0] demodSpaceBase = 6'b000000;

    // word offsets within the block
    localparam logic [5:0] regMode      = 6'd0;
    localparam logic [5:0] regFalseLock = 6'd1;
    localparam logic [5:0] regDacSelect = 6'd2;
    localparam logic [5:0] regStatus    = 6'd3;

    // discriminator values sit at the top of a sample
    localparam int discScale = 10;

endpackage

`default_nettype wire
